/* loopIsaPkg.sv */
package loopIsaPkg;

    // instruction byte, also carries immediates and jump targets
    typedef logic [7:0] insT;

    // high nibble of the instruction
    typedef logic [3:0] opcodeT;

    // low nibble, lane number for JMP, LIMIT and INC
    typedef logic [3:0] subCodeT;

    localparam opcodeT OpNoop    = 4'd0;
    localparam opcodeT OpJmp     = 4'd1;
    localparam opcodeT OpLimit   = 4'd4;   // limit comes from the next ROM byte
    localparam opcodeT OpReset   = 4'd7;
    localparam opcodeT OpInc     = 4'd10;
    localparam opcodeT OpEnd     = 4'd12;
    localparam opcodeT OpChkIdle = 4'd13;

    // RESET sub-codes, counters only
    localparam subCodeT RstAll = 4'd0;
    localparam subCodeT RstN   = 4'd1;
    localparam subCodeT RstK   = 4'd2;
    localparam subCodeT RstM   = 4'd3;

    // sequencer states
    typedef enum logic [2:0] {
        SStart,     // first fetch after reset
        SWaitIns,   // instruction read in flight
        SDecode,
        SWaitImm,   // LIMIT immediate read in flight
        SCmpWait,   // resolver registers the zero flag
        SZeroChk,
        SWaitTgt,   // jump target read in flight
        SDone
    } seqStateT;

endpackage

/* loopDataPkg.sv */
package loopDataPkg;

    // loop nests M, K and N
    localparam int NumLanes = 3;

    // lane index, also the compare select
    typedef logic [1:0] laneIdxT;

    localparam laneIdxT LaneM = 2'd0;   // outer nest, its exhaustion ends the core
    localparam laneIdxT LaneK = 2'd1;
    localparam laneIdxT LaneN = 2'd2;

    // program counter into the instruction ROM
    typedef logic [7:0] pcT;

    // loop count and limit
    typedef logic [7:0] countT;

endpackage

/* laneCtrlIf.sv */
`timescale 1ns/1ps

interface laneCtrlIf
    import loopDataPkg::*;
();

    logic  incr;        // count + 1
    logic  clear;       // count back to 0, wins over incr
    logic  loadLimit;
    countT limitValue;
    logic  atLimit;     // count equals limit

    modport seq (
        output incr,
        output clear,
        output loadLimit,
        output limitValue
    );

    modport lane (
        input  incr,
        input  clear,
        input  loadLimit,
        input  limitValue,
        output atLimit
    );

    modport mon (input atLimit);

endinterface

/* loopCounterLane.sv */
`timescale 1ns/1ps

module loopCounterLane
    import loopDataPkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    laneCtrlIf.lane ctrl
);

    countT limit;
    countT count;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            limit <= '0;
            count <= '0;
        end else begin
            if (ctrl.clear) begin
                count <= '0;
            end else if (ctrl.incr) begin
                count <= count + 1'b1;   // wraps at 8 bits
            end
            if (ctrl.loadLimit) begin
                limit <= ctrl.limitValue;
            end
        end
    end

    // nest exhausted
    assign ctrl.atLimit = (count == limit);

endmodule

/* zeroResolver.sv */
`timescale 1ns/1ps

module zeroResolver
    import loopDataPkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    laneCtrlIf.mon  lanes [NumLanes],
    input  logic    cmpValid,
    input  laneIdxT cmpLane,
    output logic    zero
);

    logic [NumLanes-1:0] atLimitV;

    for (genvar g = 0; g < NumLanes; g++) begin : laneTap
        assign atLimitV[g] = lanes[g].atLimit;
    end

    // flag holds until the next compare
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            zero <= 1'b0;
        end else if (cmpValid) begin
            if (int'(cmpLane) < NumLanes) begin
                zero <= atLimitV[cmpLane];
            end else begin
                zero <= 1'b0;   // no such lane, never exhausted
            end
        end
    end

endmodule

/* controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer
    import loopIsaPkg::*, loopDataPkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    output logic    iromRead,
    output pcT      pc,
    input  logic    iromValid,
    input  insT     iromData,
    laneCtrlIf.seq  lanes [NumLanes],
    output logic    cmpValid,
    output laneIdxT cmpLane,
    input  logic    zero,
    output logic    coreDone
);

    seqStateT            state;
    insT                 insQ;        // current instruction
    countT               limitQ;      // immediate for LIMIT
    opcodeT              opcode;
    subCodeT             subCode;
    logic [NumLanes-1:0] laneSel;     // lane named by the sub-code
    logic [NumLanes-1:0] rstSel;      // lanes cleared by RESET
    logic                endOnZero;
    logic [NumLanes-1:0] incrQ;
    logic [NumLanes-1:0] clearQ;
    logic [NumLanes-1:0] loadQ;

    assign opcode  = opcodeT'(insQ[7:4]);
    assign subCode = subCodeT'(insQ[3:0]);

    // exhausted M means the work is done
    assign endOnZero = (opcode == OpChkIdle) || (subCode == subCodeT'(LaneM));

    always_comb begin
        laneSel = '0;
        for (int i = 0; i < NumLanes; i++) begin
            if (subCode == subCodeT'(i)) begin
                laneSel[i] = 1'b1;
            end
        end
    end

    always_comb begin
        rstSel = '0;
        case (subCode)
            RstAll:  rstSel = '1;
            RstN:    rstSel[LaneN] = 1'b1;
            RstK:    rstSel[LaneK] = 1'b1;
            RstM:    rstSel[LaneM] = 1'b1;
            default: rstSel = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state    <= SStart;
            pc       <= '0;
            iromRead <= 1'b0;
            cmpValid <= 1'b0;
            cmpLane  <= '0;
            coreDone <= 1'b0;
            incrQ    <= '0;
            clearQ   <= '0;
            loadQ    <= '0;
        end else begin
            // all strobes are one-cycle pulses
            iromRead <= 1'b0;
            cmpValid <= 1'b0;
            incrQ    <= '0;
            clearQ   <= '0;
            loadQ    <= '0;
            case (state)
                SStart: begin
                    iromRead <= 1'b1;
                    state    <= SWaitIns;
                end
                SWaitIns: begin
                    if (iromValid) begin
                        pc    <= pc + 1'b1;
                        state <= SDecode;
                    end
                end
                SDecode: begin
                    state <= SWaitIns;
                    case (opcode)
                        OpNoop:  iromRead <= 1'b1;
                        OpReset: begin
                            clearQ   <= rstSel;
                            iromRead <= 1'b1;
                        end
                        OpInc: begin
                            incrQ    <= laneSel;
                            iromRead <= 1'b1;
                        end
                        OpLimit: begin
                            iromRead <= 1'b1;   // pc already on the immediate
                            state    <= SWaitImm;
                        end
                        OpJmp: begin
                            cmpValid <= 1'b1;
                            cmpLane  <= laneIdxT'(subCode);
                            state    <= SCmpWait;
                        end
                        OpChkIdle: begin
                            cmpValid <= 1'b1;
                            cmpLane  <= LaneM;
                            state    <= SCmpWait;
                        end
                        OpEnd: begin
                            coreDone <= 1'b1;
                            state    <= SDone;
                        end
                        default: iromRead <= 1'b1;   // undefined codes act as NOOP
                    endcase
                end
                SWaitImm: begin
                    if (iromValid) begin
                        loadQ    <= laneSel;
                        pc       <= pc + 1'b1;
                        iromRead <= 1'b1;
                        state    <= SWaitIns;
                    end
                end
                SCmpWait: state <= SZeroChk;
                SZeroChk: begin
                    iromRead <= 1'b1;
                    state    <= SWaitIns;
                    if (zero && endOnZero) begin
                        iromRead <= 1'b0;
                        coreDone <= 1'b1;
                        state    <= SDone;
                    end else if (zero) begin
                        pc <= pc + 1'b1;          // step over the target byte
                    end else if (opcode == OpJmp) begin
                        state <= SWaitTgt;        // read the target at pc
                    end
                end
                SWaitTgt: begin
                    if (iromValid) begin
                        pc       <= pcT'(iromData);
                        iromRead <= 1'b1;
                        state    <= SWaitIns;
                    end
                end
                SDone:   coreDone <= 1'b1;    // held until reset
                default: state <= SStart;
            endcase
        end
    end

    // instruction and immediate bytes
    always_ff @(posedge Clk) begin
        if (state == SWaitIns && iromValid) begin
            insQ <= iromData;
        end
        if (state == SWaitImm && iromValid) begin
            limitQ <= countT'(iromData);
        end
    end

    for (genvar g = 0; g < NumLanes; g++) begin : laneDrive
        assign lanes[g].incr       = incrQ[g];
        assign lanes[g].clear      = clearQ[g];
        assign lanes[g].loadLimit  = loadQ[g];
        assign lanes[g].limitValue = limitQ;   // shared, only the loaded lane takes it
    end

endmodule

/* loopCore.sv */
`timescale 1ns/1ps

module loopCore
    import loopIsaPkg::*, loopDataPkg::*;
(
    input  logic Clk,
    input  logic arstN,
    output logic iromRead,
    output pcT   pc,
    input  logic iromValid,
    input  insT  iromData,
    output logic coreDone
);

    logic    cmpValid;
    laneIdxT cmpLane;
    logic    zero;

    // one control bundle per loop nest
    laneCtrlIf laneBus [NumLanes] ();

    controlSequencer seq_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .iromRead  (iromRead),
        .pc        (pc),
        .iromValid (iromValid),
        .iromData  (iromData),
        .lanes     (laneBus),
        .cmpValid  (cmpValid),
        .cmpLane   (cmpLane),
        .zero      (zero),
        .coreDone  (coreDone)
    );

    for (genvar g = 0; g < NumLanes; g++) begin : laneGen
        loopCounterLane lane_i (
            .Clk   (Clk),
            .arstN (arstN),
            .ctrl  (laneBus[g])
        );
    end

    // registered zero flag for JMP and CHK_IDLE
    zeroResolver zeroRes_i (
        .Clk      (Clk),
        .arstN    (arstN),
        .lanes    (laneBus),
        .cmpValid (cmpValid),
        .cmpLane  (cmpLane),
        .zero     (zero)
    );

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic Clk,
    output logic arstN,
    input  logic rstReq     // extra reset between tests
);

    logic porDone;

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;   // 40 ns period
    end

    // power-on reset for the first 2 cycles
    initial begin
        porDone = 1'b0;
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        porDone = 1'b1;
    end

    assign arstN = porDone && !rstReq;

endmodule

/* loopCoreProperties.sv */
`timescale 1ns/1ps

module loopCoreProperties
    import loopIsaPkg::*;
(
    input logic     Clk,
    input logic     arstN,
    input logic     iromRead,
    input logic     iromValid,
    input logic     coreDone,
    input seqStateT seqState
);

    logic pending;   // read issued and valid not yet seen

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pending <= 1'b0;
        end else if (iromRead) begin
            pending <= 1'b1;
        end else if (iromValid) begin
            pending <= 1'b0;
        end
    end

    noReadInFlight: assert property (@(posedge Clk) disable iff (!arstN)
        pending |-> !iromRead)
        else $error("second ROM read before valid");

    doneSticky: assert property (@(posedge Clk) disable iff (!arstN)
        coreDone |=> coreDone)
        else $error("coreDone dropped without reset");

    noReadWhenDone: assert property (@(posedge Clk) disable iff (!arstN)
        coreDone |-> !iromRead)
        else $error("ROM read after coreDone");

    // a valid that arrives outside a wait state would be lost
    validWhileWaiting: assert property (@(posedge Clk) disable iff (!arstN)
        iromValid |-> seqState inside {SWaitIns, SWaitImm, SWaitTgt})
        else $error("ROM valid while the sequencer was not waiting for it");

    quietAfterReset: assert property (@(posedge Clk)
        $rose(arstN) |-> !iromRead && !coreDone)
        else $error("outputs active right after reset");

endmodule

/* loopCoreTb.sv */
`timescale 1ns/1ps

module loopCoreTb
    import loopIsaPkg::*, loopDataPkg::*;
();

    localparam int ProgLen     = 40;
    localparam int NumTests    = 4;
    localparam int WatchCycles = NumTests * ProgLen * 12 * 5;

    logic  Clk;
    logic  arstN;
    logic  rstReq;
    logic  iromRead;
    pcT    pc;
    logic  iromValid;
    insT   iromData;
    logic  coreDone;

    int    seed = 32'h3fd1;
    insT   rom [256];
    pcT    expQ [$];        // expected read addresses, in order
    string testName;
    int    errCount;
    int    testErr;
    int    checkCount;
    int    testCount;
    int    waitCnt;
    pcT    reqPc;

    tbClock clk_i (
        .Clk    (Clk),
        .arstN  (arstN),
        .rstReq (rstReq)
    );

    loopCore dut_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .iromRead  (iromRead),
        .pc        (pc),
        .iromValid (iromValid),
        .iromData  (iromData),
        .coreDone  (coreDone)
    );

    bind loopCore loopCoreProperties props_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .iromRead  (iromRead),
        .iromValid (iromValid),
        .coreDone  (coreDone),
        .seqState  (seq_i.state)
    );

    // ROM model, valid after 1 to 4 cycles
    always @(negedge Clk) begin
        iromValid = 1'b0;
        if (!arstN) begin
            waitCnt = 0;
        end else if (waitCnt > 0) begin
            waitCnt = waitCnt - 1;
            if (waitCnt == 0) begin
                iromValid = 1'b1;
                iromData  = rom[reqPc];
            end
        end else if (iromRead) begin
            reqPc   = pc;
            waitCnt = 1 + ($unsigned($random(seed)) % 4);
            if (expQ.size() == 0) begin
                errCount++;
                testErr++;
                $display("ERROR %s: unexpected read at pc %0d after the program ended",
                         testName, pc);
            end else begin
                checkCount++;
                if (pc !== expQ[0]) begin
                    errCount++;
                    testErr++;
                    $display("FAILED %s: expected pc %0d, actual pc %0d",
                             testName, expQ[0], pc);
                end
                void'(expQ.pop_front());
            end
        end
    end

    // random program with forward jumps only, so it always terminates
    task automatic genProgram(input logic directed);
        int      a;
        int      p;
        int      r;
        int      starts [$];
        int      jmps [$];
        int      cand [$];
        subCodeT lane;
        for (int i = 0; i < 256; i++) begin
            rom[i] = {OpEnd, 4'(i[7:4] ^ i[3:0])};
        end
        a = 0;
        if (directed) begin
            rom[0]  = {OpLimit, 4'd0};   // M limit 2
            rom[1]  = 8'd2;
            rom[2]  = {OpLimit, 4'd1};   // K limit 3
            rom[3]  = 8'd3;
            rom[4]  = {OpInc, 4'd1};
            rom[5]  = {OpInc, 4'd1};
            rom[6]  = {OpInc, 4'd1};
            rom[7]  = {OpJmp, 4'd1};     // K exhausted, skipped
            rom[8]  = 8'd12;
            rom[9]  = {OpReset, RstK};
            rom[10] = {OpJmp, 4'd1};     // K cleared, taken
            rom[11] = 8'd12;
            starts = '{0, 2, 4, 5, 6, 7, 9, 10};
            a = 12;
        end
        while (a < ProgLen - 3) begin
            starts.push_back(a);
            r    = $unsigned($random(seed)) % 8;
            lane = subCodeT'($unsigned($random(seed)) % 3);
            case (r)
                1, 6: begin
                    rom[a] = {OpJmp, lane};
                    jmps.push_back(a);
                    a += 2;
                end
                2: begin
                    rom[a]     = {OpLimit, lane};
                    rom[a + 1] = insT'($unsigned($random(seed)) % 4);   // small limits
                    a += 2;
                end
                3: begin
                    rom[a] = {OpReset, subCodeT'($unsigned($random(seed)) % 4)};
                    a++;
                end
                4, 7: begin
                    rom[a] = {OpInc, lane};
                    a++;
                end
                5: begin
                    rom[a] = {OpChkIdle, 4'd0};
                    a++;
                end
                default: begin
                    rom[a] = {OpNoop, 4'd0};
                    a++;
                end
            endcase
        end
        starts.push_back(a);
        rom[a] = {OpEnd, 4'd0};
        // targets land on a later instruction start
        foreach (jmps[i]) begin
            p = jmps[i];
            cand.delete();
            foreach (starts[j]) begin
                if (starts[j] > p + 1) cand.push_back(starts[j]);
            end
            rom[p + 1] = insT'(cand[$unsigned($random(seed)) % cand.size()]);
        end
    endtask

    // ISA model, lists every ROM read the core should make
    task automatic buildExpected();
        int      p;
        int      guard;
        int      ln;
        countT   cnt [NumLanes];
        countT   lim [NumLanes];
        logic    fin;
        logic    z;
        opcodeT  op;
        subCodeT sub;
        expQ.delete();
        for (int i = 0; i < NumLanes; i++) begin
            cnt[i] = '0;
            lim[i] = '0;
        end
        p     = 0;
        fin   = 1'b0;
        guard = 0;
        while (!fin && guard < 1000) begin
            guard++;
            expQ.push_back(pcT'(p));
            op  = rom[p][7:4];
            sub = rom[p][3:0];
            case (op)
                OpLimit: begin
                    expQ.push_back(pcT'(p + 1));
                    if (int'(sub) < NumLanes) lim[int'(sub)] = rom[(p + 1) % 256];
                    p += 2;
                end
                OpReset: begin
                    if (sub == RstAll || sub == RstN) cnt[2] = '0;
                    if (sub == RstAll || sub == RstK) cnt[1] = '0;
                    if (sub == RstAll || sub == RstM) cnt[0] = '0;
                    p++;
                end
                OpInc: begin
                    if (int'(sub) < NumLanes) cnt[int'(sub)] = cnt[int'(sub)] + 1'b1;
                    p++;
                end
                OpJmp: begin
                    ln = int'(sub[1:0]);
                    z  = (ln < NumLanes) ? (cnt[ln] == lim[ln]) : 1'b0;
                    if (z && sub == 4'd0) begin
                        fin = 1'b1;           // outer nest exhausted
                    end else if (z) begin
                        p += 2;
                    end else begin
                        expQ.push_back(pcT'(p + 1));
                        p = int'(rom[(p + 1) % 256]);
                    end
                end
                OpChkIdle: begin
                    if (cnt[0] == lim[0]) fin = 1'b1;
                    else p++;
                end
                OpEnd:   fin = 1'b1;
                default: p++;
            endcase
            p = p % 256;
        end
    endtask

    task automatic runTest(input string name, input logic directed);
        testName = name;
        testErr  = 0;
        testCount++;
        @(negedge Clk);
        rstReq = 1'b1;
        genProgram(directed);
        buildExpected();
        repeat (2) @(negedge Clk);
        if (pc !== 8'd0 || coreDone !== 1'b0) begin
            errCount++;
            testErr++;
            $display("FAILED %s reset: expected pc 0 done 0, actual pc %0d done %b",
                     name, pc, coreDone);
        end
        rstReq = 1'b0;
        while (coreDone !== 1'b1) @(negedge Clk);
        repeat (8) @(negedge Clk);   // no reads may follow
        if (expQ.size() != 0) begin
            errCount++;
            testErr++;
            $display("ERROR %s: core finished with %0d expected reads missing",
                     name, expQ.size());
        end
        if (coreDone !== 1'b1) begin
            errCount++;
            testErr++;
            $display("FAILED %s done: expected 1, actual %b", name, coreDone);
        end
        $display("test %s finished with %0d errors", name, testErr);
    endtask

    initial begin
        rstReq     = 1'b1;
        iromValid  = 1'b0;
        iromData   = '0;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        waitCnt    = 0;
        testName   = "none";
        runTest("directed", 1'b1);
        runTest("random1", 1'b0);
        runTest("random2", 1'b0);
        runTest("random3", 1'b0);
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WatchCycles) @(posedge Clk);
        $display("ERROR: watchdog expired, the core hung in test %s", testName);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* loopCore.f */
loopIsaPkg.sv
loopDataPkg.sv
laneCtrlIf.sv
loopCounterLane.sv
zeroResolver.sv
controlSequencer.sv
loopCore.sv
tbClock.sv
loopCoreProperties.sv
loopCoreTb.sv

/* Bender.yml */
package:
  name: loopCore

sources:
  - files:
      - loopIsaPkg.sv
      - loopDataPkg.sv
      - laneCtrlIf.sv
      - loopCounterLane.sv
      - zeroResolver.sv
      - controlSequencer.sv
      - loopCore.sv
  - target: test
    files:
      - tbClock.sv
      - loopCoreProperties.sv
      - loopCoreTb.sv
